// ==== design/corebus_pkg.sv ====
// Shared widths, depths, command codes and payload types for the AXI to corebus memory.
// Every design file refers to these by scoped names.
`default_nettype none

package corebus_pkg;

  localparam int AXI_ID_WIDTH    = 4;
  localparam int ADDR_WIDTH      = 16;
  localparam int DATA_WIDTH      = 32;
  localparam int BYTEEN_WIDTH    = 4;
  localparam int LENGTH_WIDTH    = 5;   // Holds burst lengths 1 to 16.
  localparam int MEM_WORDS       = 256;
  localparam int CMD_FIFO_DEPTH  = 2;
  localparam int DATA_FIFO_DEPTH = 2;
  localparam int BID_FIFO_DEPTH  = 4;   // Also the limit of pending B responses.

  typedef enum logic {
    CB_READ  = 1'b0,
    CB_WRITE = 1'b1
  } corebus_command_e;

  typedef logic [AXI_ID_WIDTH-1:0] axi_id_t;

  typedef struct packed {
    corebus_command_e        cmd;
    axi_id_t                 id;
    logic [ADDR_WIDTH-1:0]   addr;    // Word aligned.
    logic [LENGTH_WIDTH-1:0] length;
  } corebus_cmd_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]   data;
    logic [BYTEEN_WIDTH-1:0] byteen;
    logic                    last;
  } corebus_data_t;

endpackage

`default_nettype wire

// ==== design/corebus_fifo.sv ====
// Synchronous circular-buffer FIFO for command, write-data and ID payloads.
// The depth follows from the payload type.
`default_nettype none

module corebus_fifo #(
  parameter type T = corebus_pkg::corebus_cmd_t
) (
  input  var logic i_clk,
  input  var logic i_rst_n,
  input  var logic i_push,
  input  var T     i_data,
  output logic     o_full,
  input  var logic i_pop,
  output T         o_data,
  output logic     o_empty
);

  localparam int DEPTH =
    ($bits(T) == $bits(corebus_pkg::corebus_data_t)) ? corebus_pkg::DATA_FIFO_DEPTH :
    ($bits(T) == $bits(corebus_pkg::axi_id_t))       ? corebus_pkg::BID_FIFO_DEPTH  :
                                                       corebus_pkg::CMD_FIFO_DEPTH;
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  T                       mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  assign o_empty = (count == COUNT_WIDTH'(0));
  assign o_full  = (count == COUNT_WIDTH'(DEPTH));
  assign do_pop  = i_pop && !o_empty;
  assign do_push = i_push && (!o_full || do_pop); // A pop frees the slot in the same cycle.
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + PTR_WIDTH'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + PTR_WIDTH'(1);
      end
      if (do_push && !do_pop) begin
        count <= count + COUNT_WIDTH'(1);
      end else if (do_pop && !do_push) begin
        count <= count - COUNT_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/corebus_rr_switch.sv ====
// Two-port corebus switch: round-robin between read and write commands, write data
// steered to the memory, read responses returned to the read port.
`default_nettype none

module corebus_rr_switch (
  input  var logic                                 i_clk,
  input  var logic                                 i_rst_n,
  // Port 0, read master.
  input  var logic                                 i_rd_cmd_valid,
  output logic                                     o_rd_cmd_accept,
  input  var corebus_pkg::corebus_cmd_t            i_rd_cmd,
  output logic                                     o_rd_resp_valid,
  input  var logic                                 i_rd_resp_accept,
  output corebus_pkg::axi_id_t                     o_rd_resp_id,
  output logic [corebus_pkg::DATA_WIDTH-1:0]       o_rd_resp_data,
  output logic                                     o_rd_resp_error,
  output logic                                     o_rd_resp_last,
  // Port 1, write master.
  input  var logic                                 i_wr_cmd_valid,
  output logic                                     o_wr_cmd_accept,
  input  var corebus_pkg::corebus_cmd_t            i_wr_cmd,
  input  var logic                                 i_wr_data_valid,
  output logic                                     o_wr_data_accept,
  input  var corebus_pkg::corebus_data_t           i_wr_data,
  // Memory side.
  output logic                                     o_cmd_valid,
  input  var logic                                 i_cmd_accept,
  output corebus_pkg::corebus_cmd_t                o_cmd,
  output logic                                     o_data_valid,
  input  var logic                                 i_data_accept,
  output corebus_pkg::corebus_data_t               o_data,
  input  var logic                                 i_resp_valid,
  output logic                                     o_resp_accept,
  input  var corebus_pkg::axi_id_t                 i_resp_id,
  input  var logic [corebus_pkg::DATA_WIDTH-1:0]   i_resp_data,
  input  var logic                                 i_resp_error,
  input  var logic                                 i_resp_last
);

  logic rr_ptr;     // Port that wins when both request.
  logic grant;      // 0 is read, 1 is write.
  logic wr_lock;    // Write owns the bus until its last data beat.
  logic cmd_done;

  always_comb begin
    if (i_rd_cmd_valid && i_wr_cmd_valid) begin
      grant = rr_ptr;
    end else begin
      grant = i_wr_cmd_valid;
    end
  end

  assign o_cmd_valid     = !wr_lock && (grant ? i_wr_cmd_valid : i_rd_cmd_valid);
  assign o_cmd           = grant ? i_wr_cmd : i_rd_cmd;
  assign o_rd_cmd_accept = !wr_lock && !grant && i_cmd_accept;
  assign o_wr_cmd_accept = !wr_lock && grant && i_cmd_accept;
  assign cmd_done        = o_cmd_valid && i_cmd_accept;

  assign o_data_valid     = i_wr_data_valid;
  assign o_data           = i_wr_data;
  assign o_wr_data_accept = i_data_accept;

  assign o_rd_resp_valid = i_resp_valid;  // Writes are posted, so every response is a read.
  assign o_resp_accept   = i_rd_resp_accept;
  assign o_rd_resp_id    = i_resp_id;
  assign o_rd_resp_data  = i_resp_data;
  assign o_rd_resp_error = i_resp_error;
  assign o_rd_resp_last  = i_resp_last;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rr_ptr  <= 1'b0;
      wr_lock <= 1'b0;
    end else begin
      if (cmd_done) begin
        rr_ptr <= !grant;
      end
      if (cmd_done && grant) begin
        wr_lock <= 1'b1;
      end else if (i_wr_data_valid && i_data_accept && i_wr_data.last) begin
        wr_lock <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/axi2corebus_bridge.sv ====
// AXI4 slave to corebus bridge with separate read and write master ports.
// Writes are posted and B responses are generated locally in AW order.
`default_nettype none

module axi2corebus_bridge (
  input  var logic                                    i_clk,
  input  var logic                                    i_rst_n,
  input  var logic                                    i_axi_awvalid,
  output logic                                        o_axi_awready,
  input  var corebus_pkg::axi_id_t                    i_axi_awid,
  input  var logic [corebus_pkg::ADDR_WIDTH-1:0]      i_axi_awaddr,
  input  var logic [7:0]                              i_axi_awlen,
  input  var logic                                    i_axi_wvalid,
  output logic                                        o_axi_wready,
  input  var logic [corebus_pkg::DATA_WIDTH-1:0]      i_axi_wdata,
  input  var logic [corebus_pkg::BYTEEN_WIDTH-1:0]    i_axi_wstrb,
  input  var logic                                    i_axi_wlast,
  output logic                                        o_axi_bvalid,
  input  var logic                                    i_axi_bready,
  output corebus_pkg::axi_id_t                        o_axi_bid,
  output logic [1:0]                                  o_axi_bresp,
  input  var logic                                    i_axi_arvalid,
  output logic                                        o_axi_arready,
  input  var corebus_pkg::axi_id_t                    i_axi_arid,
  input  var logic [corebus_pkg::ADDR_WIDTH-1:0]      i_axi_araddr,
  input  var logic [7:0]                              i_axi_arlen,
  output logic                                        o_axi_rvalid,
  input  var logic                                    i_axi_rready,
  output corebus_pkg::axi_id_t                        o_axi_rid,
  output logic [corebus_pkg::DATA_WIDTH-1:0]          o_axi_rdata,
  output logic [1:0]                                  o_axi_rresp,
  output logic                                        o_axi_rlast,
  output logic                                        o_rd_cmd_valid,
  input  var logic                                    i_rd_cmd_accept,
  output corebus_pkg::corebus_cmd_t                   o_rd_cmd,
  input  var logic                                    i_rd_resp_valid,
  output logic                                        o_rd_resp_accept,
  input  var corebus_pkg::axi_id_t                    i_rd_resp_id,
  input  var logic [corebus_pkg::DATA_WIDTH-1:0]      i_rd_resp_data,
  input  var logic                                    i_rd_resp_error,
  input  var logic                                    i_rd_resp_last,
  output logic                                        o_wr_cmd_valid,
  input  var logic                                    i_wr_cmd_accept,
  output corebus_pkg::corebus_cmd_t                   o_wr_cmd,
  output logic                                        o_wr_data_valid,
  input  var logic                                    i_wr_data_accept,
  output corebus_pkg::corebus_data_t                  o_wr_data
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int         BCNT_WIDTH  = $clog2(corebus_pkg::BID_FIFO_DEPTH + 1);
  localparam int         LW          = corebus_pkg::LENGTH_WIDTH;

  corebus_pkg::corebus_cmd_t  rd_cmd_in;
  corebus_pkg::corebus_cmd_t  wr_cmd_in;
  corebus_pkg::corebus_data_t wr_data_in;
  logic                       rd_cmd_full, rd_cmd_empty;
  logic                       wr_cmd_full, wr_cmd_empty;
  logic                       wr_data_full, wr_data_empty;
  logic                       bid_full, bid_empty;
  logic                       ar_fire, aw_fire, wlast_fire, b_fire;
  logic [BCNT_WIDTH-1:0]      bcount;

  always_comb begin
    rd_cmd_in.cmd    = corebus_pkg::CB_READ;
    rd_cmd_in.id     = i_axi_arid;
    rd_cmd_in.addr   = {i_axi_araddr[corebus_pkg::ADDR_WIDTH-1:2], 2'b00};
    rd_cmd_in.length = LW'(i_axi_arlen) + LW'(1);
    wr_cmd_in.cmd    = corebus_pkg::CB_WRITE;
    wr_cmd_in.id     = i_axi_awid;
    wr_cmd_in.addr   = {i_axi_awaddr[corebus_pkg::ADDR_WIDTH-1:2], 2'b00};
    wr_cmd_in.length = LW'(i_axi_awlen) + LW'(1);
    wr_data_in.data   = i_axi_wdata;
    wr_data_in.byteen = i_axi_wstrb;
    wr_data_in.last   = i_axi_wlast;
  end

  assign o_axi_arready = !rd_cmd_full;
  assign ar_fire       = i_axi_arvalid && o_axi_arready;
  assign o_rd_cmd_valid = !rd_cmd_empty;

  // R beats pass straight through from the corebus response channel.
  assign o_axi_rvalid     = i_rd_resp_valid;
  assign o_rd_resp_accept = i_axi_rready;
  assign o_axi_rid        = i_rd_resp_id;
  assign o_axi_rdata      = i_rd_resp_data;
  assign o_axi_rresp      = i_rd_resp_error ? RESP_SLVERR : RESP_OKAY;
  assign o_axi_rlast      = i_rd_resp_last;

  assign o_axi_awready   = !bid_full && !wr_cmd_full;
  assign aw_fire         = i_axi_awvalid && o_axi_awready;
  assign o_wr_cmd_valid  = !wr_cmd_empty;
  assign o_axi_wready    = (bcount != BCNT_WIDTH'(corebus_pkg::BID_FIFO_DEPTH)) && !wr_data_full;
  assign wlast_fire      = i_axi_wvalid && o_axi_wready && i_axi_wlast;
  assign o_wr_data_valid = !wr_data_empty;

  assign o_axi_bvalid = (bcount != BCNT_WIDTH'(0)) && !bid_empty;
  assign o_axi_bresp  = RESP_OKAY;
  assign b_fire       = o_axi_bvalid && i_axi_bready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bcount <= '0;
    end else if (wlast_fire && !b_fire) begin
      bcount <= bcount + BCNT_WIDTH'(1);
    end else if (b_fire && !wlast_fire) begin
      bcount <= bcount - BCNT_WIDTH'(1);
    end
  end

  corebus_fifo #(.T(corebus_pkg::corebus_cmd_t)) u_rd_cmd_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_push(ar_fire), .i_data(rd_cmd_in), .o_full(rd_cmd_full),
    .i_pop(i_rd_cmd_accept), .o_data(o_rd_cmd), .o_empty(rd_cmd_empty)
  );

  corebus_fifo #(.T(corebus_pkg::corebus_cmd_t)) u_wr_cmd_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_push(aw_fire), .i_data(wr_cmd_in), .o_full(wr_cmd_full),
    .i_pop(i_wr_cmd_accept), .o_data(o_wr_cmd), .o_empty(wr_cmd_empty)
  );

  corebus_fifo #(.T(corebus_pkg::corebus_data_t)) u_wr_data_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_push(i_axi_wvalid && o_axi_wready), .i_data(wr_data_in), .o_full(wr_data_full),
    .i_pop(i_wr_data_accept), .o_data(o_wr_data), .o_empty(wr_data_empty)
  );

  corebus_fifo #(.T(corebus_pkg::axi_id_t)) u_bid_fifo (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_push(aw_fire), .i_data(i_axi_awid), .o_full(bid_full),
    .i_pop(b_fire), .o_data(o_axi_bid), .o_empty(bid_empty)
  );

endmodule

`default_nettype wire

// ==== design/corebus_sram.sv ====
// Corebus memory target serving one read or write burst at a time.
// Out-of-range beats read as zero with an error and are dropped on write.
`default_nettype none

module corebus_sram (
  input  var logic                                 i_clk,
  input  var logic                                 i_rst_n,
  input  var logic                                 i_cmd_valid,
  output logic                                     o_cmd_accept,
  input  var corebus_pkg::corebus_cmd_t            i_cmd,
  input  var logic                                 i_data_valid,
  output logic                                     o_data_accept,
  input  var corebus_pkg::corebus_data_t           i_data,
  output logic                                     o_resp_valid,
  input  var logic                                 i_resp_accept,
  output corebus_pkg::axi_id_t                     o_resp_id,
  output logic [corebus_pkg::DATA_WIDTH-1:0]       o_resp_data,
  output logic                                     o_resp_error,
  output logic                                     o_resp_last
);

  localparam int WADDR_WIDTH = corebus_pkg::ADDR_WIDTH - 2;
  localparam int INDEX_WIDTH = $clog2(corebus_pkg::MEM_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  logic [corebus_pkg::DATA_WIDTH-1:0]   mem [corebus_pkg::MEM_WORDS];
  state_e                               state;
  logic [WADDR_WIDTH-1:0]               waddr;
  logic [corebus_pkg::LENGTH_WIDTH-1:0] length;
  logic [corebus_pkg::LENGTH_WIDTH-1:0] beat;
  corebus_pkg::axi_id_t                 id;
  logic                                 in_range;
  logic                                 resp_fire;
  logic                                 data_fire;

  assign in_range      = (waddr < WADDR_WIDTH'(corebus_pkg::MEM_WORDS)); // Checked per beat.
  assign o_cmd_accept  = (state == ST_IDLE);
  assign o_data_accept = (state == ST_WRITE);
  assign o_resp_valid  = (state == ST_READ);
  assign o_resp_id     = id;
  assign o_resp_data   = in_range ? mem[waddr[INDEX_WIDTH-1:0]] : '0;
  assign o_resp_error  = !in_range;
  assign o_resp_last   = (beat == length);
  assign resp_fire     = o_resp_valid && i_resp_accept;
  assign data_fire     = o_data_accept && i_data_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= ST_IDLE;
      waddr  <= '0;
      length <= '0;
      beat   <= '0;
      id     <= '0;
    end else begin
      case (state)
        ST_IDLE: if (i_cmd_valid) begin
          waddr  <= i_cmd.addr[corebus_pkg::ADDR_WIDTH-1:2];
          length <= i_cmd.length;
          beat   <= corebus_pkg::LENGTH_WIDTH'(1);
          id     <= i_cmd.id;
          state  <= (i_cmd.cmd == corebus_pkg::CB_WRITE) ? ST_WRITE : ST_READ;
        end
        ST_READ: if (resp_fire) begin
          waddr <= waddr + WADDR_WIDTH'(1);
          beat  <= beat + corebus_pkg::LENGTH_WIDTH'(1);
          if (o_resp_last) begin
            state <= ST_IDLE;
          end
        end
        ST_WRITE: if (data_fire) begin
          waddr <= waddr + WADDR_WIDTH'(1);
          if (i_data.last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (data_fire && in_range) begin
      for (int b = 0; b < corebus_pkg::BYTEEN_WIDTH; b++) begin
        if (i_data.byteen[b]) begin
          mem[waddr[INDEX_WIDTH-1:0]][b*8 +: 8] <= i_data.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_corebus_top.sv ====
// Top level of the AXI4 slave memory: bridge, round-robin switch and memory target.
`default_nettype none

module axi_corebus_top (
  input  var logic                                 i_clk,
  input  var logic                                 i_rst_n,
  input  var logic                                 i_axi_awvalid,
  output logic                                     o_axi_awready,
  input  var corebus_pkg::axi_id_t                 i_axi_awid,
  input  var logic [corebus_pkg::ADDR_WIDTH-1:0]   i_axi_awaddr,
  input  var logic [7:0]                           i_axi_awlen,
  input  var logic                                 i_axi_wvalid,
  output logic                                     o_axi_wready,
  input  var logic [corebus_pkg::DATA_WIDTH-1:0]   i_axi_wdata,
  input  var logic [corebus_pkg::BYTEEN_WIDTH-1:0] i_axi_wstrb,
  input  var logic                                 i_axi_wlast,
  output logic                                     o_axi_bvalid,
  input  var logic                                 i_axi_bready,
  output corebus_pkg::axi_id_t                     o_axi_bid,
  output logic [1:0]                               o_axi_bresp,
  input  var logic                                 i_axi_arvalid,
  output logic                                     o_axi_arready,
  input  var corebus_pkg::axi_id_t                 i_axi_arid,
  input  var logic [corebus_pkg::ADDR_WIDTH-1:0]   i_axi_araddr,
  input  var logic [7:0]                           i_axi_arlen,
  output logic                                     o_axi_rvalid,
  input  var logic                                 i_axi_rready,
  output corebus_pkg::axi_id_t                     o_axi_rid,
  output logic [corebus_pkg::DATA_WIDTH-1:0]       o_axi_rdata,
  output logic [1:0]                               o_axi_rresp,
  output logic                                     o_axi_rlast
);

  logic                               rd_cmd_valid, rd_cmd_accept;
  logic                               rd_resp_valid, rd_resp_accept;
  logic                               rd_resp_error, rd_resp_last;
  corebus_pkg::corebus_cmd_t          rd_cmd, wr_cmd, mem_cmd;
  corebus_pkg::axi_id_t               rd_resp_id, mem_resp_id;
  logic [corebus_pkg::DATA_WIDTH-1:0] rd_resp_data, mem_resp_data;
  logic                               wr_cmd_valid, wr_cmd_accept;
  logic                               wr_data_valid, wr_data_accept;
  corebus_pkg::corebus_data_t         wr_data, mem_data;
  logic                               mem_cmd_valid, mem_cmd_accept;
  logic                               mem_data_valid, mem_data_accept;
  logic                               mem_resp_valid, mem_resp_accept;
  logic                               mem_resp_error, mem_resp_last;

  axi2corebus_bridge u_bridge (
    .i_clk, .i_rst_n,
    .i_axi_awvalid, .o_axi_awready, .i_axi_awid, .i_axi_awaddr, .i_axi_awlen,
    .i_axi_wvalid, .o_axi_wready, .i_axi_wdata, .i_axi_wstrb, .i_axi_wlast,
    .o_axi_bvalid, .i_axi_bready, .o_axi_bid, .o_axi_bresp,
    .i_axi_arvalid, .o_axi_arready, .i_axi_arid, .i_axi_araddr, .i_axi_arlen,
    .o_axi_rvalid, .i_axi_rready, .o_axi_rid, .o_axi_rdata, .o_axi_rresp, .o_axi_rlast,
    .o_rd_cmd_valid(rd_cmd_valid), .i_rd_cmd_accept(rd_cmd_accept), .o_rd_cmd(rd_cmd),
    .i_rd_resp_valid(rd_resp_valid), .o_rd_resp_accept(rd_resp_accept),
    .i_rd_resp_id(rd_resp_id), .i_rd_resp_data(rd_resp_data),
    .i_rd_resp_error(rd_resp_error), .i_rd_resp_last(rd_resp_last),
    .o_wr_cmd_valid(wr_cmd_valid), .i_wr_cmd_accept(wr_cmd_accept), .o_wr_cmd(wr_cmd),
    .o_wr_data_valid(wr_data_valid), .i_wr_data_accept(wr_data_accept), .o_wr_data(wr_data)
  );

  corebus_rr_switch u_switch (
    .i_clk, .i_rst_n,
    .i_rd_cmd_valid(rd_cmd_valid), .o_rd_cmd_accept(rd_cmd_accept), .i_rd_cmd(rd_cmd),
    .o_rd_resp_valid(rd_resp_valid), .i_rd_resp_accept(rd_resp_accept),
    .o_rd_resp_id(rd_resp_id), .o_rd_resp_data(rd_resp_data),
    .o_rd_resp_error(rd_resp_error), .o_rd_resp_last(rd_resp_last),
    .i_wr_cmd_valid(wr_cmd_valid), .o_wr_cmd_accept(wr_cmd_accept), .i_wr_cmd(wr_cmd),
    .i_wr_data_valid(wr_data_valid), .o_wr_data_accept(wr_data_accept), .i_wr_data(wr_data),
    .o_cmd_valid(mem_cmd_valid), .i_cmd_accept(mem_cmd_accept), .o_cmd(mem_cmd),
    .o_data_valid(mem_data_valid), .i_data_accept(mem_data_accept), .o_data(mem_data),
    .i_resp_valid(mem_resp_valid), .o_resp_accept(mem_resp_accept),
    .i_resp_id(mem_resp_id), .i_resp_data(mem_resp_data),
    .i_resp_error(mem_resp_error), .i_resp_last(mem_resp_last)
  );

  corebus_sram u_sram (
    .i_clk, .i_rst_n,
    .i_cmd_valid(mem_cmd_valid), .o_cmd_accept(mem_cmd_accept), .i_cmd(mem_cmd),
    .i_data_valid(mem_data_valid), .o_data_accept(mem_data_accept), .i_data(mem_data),
    .o_resp_valid(mem_resp_valid), .i_resp_accept(mem_resp_accept),
    .o_resp_id(mem_resp_id), .o_resp_data(mem_resp_data),
    .o_resp_error(mem_resp_error), .o_resp_last(mem_resp_last)
  );

endmodule

`default_nettype wire

// ==== verif/tb_axi_corebus_top.sv ====
// Testbench for the AXI4 slave memory. Directed and random bursts are checked against a
// shadow memory, with handshake assertions on the R and B channels.
`default_nettype none

module tb_axi_corebus_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IW             = corebus_pkg::AXI_ID_WIDTH;
  localparam int AW             = corebus_pkg::ADDR_WIDTH;
  localparam int DW             = corebus_pkg::DATA_WIDTH;
  localparam int WORDS          = corebus_pkg::MEM_WORDS;
  localparam int NUM_TRANSFERS  = 156;  // Upper bound on the bursts of all tests.
  localparam int MAX_BURST      = 16;
  localparam int BP_FACTOR      = 8;
  localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * MAX_BURST * BP_FACTOR;
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic          clk;
  logic          rst_n;
  logic          awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic          arvalid, arready, rvalid, rready, rlast;
  logic [IW-1:0] awid, bid, arid, rid;
  logic [AW-1:0] awaddr, araddr;
  logic [7:0]    awlen, arlen;
  logic [DW-1:0] wdata, rdata;
  logic [3:0]    wstrb;
  logic [1:0]    bresp, rresp;

  logic [DW-1:0] shadow [WORDS];
  logic [DW-1:0] beat_data [MAX_BURST];
  logic [3:0]    beat_strb [MAX_BURST];
  logic [IW-1:0] exp_bid [$];
  logic [IW-1:0] exp_rid [$];
  logic [DW-1:0] exp_rdata [$];
  logic [1:0]    exp_rresp [$];
  logic          exp_rlast [$];
  int            seed = 32'h3267_a7eb;
  int            cycles = 0;
  logic          random_ready;
  logic [31:0]   ready_rand;

  axi_corebus_top uut (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_axi_awvalid(awvalid), .o_axi_awready(awready), .i_axi_awid(awid),
    .i_axi_awaddr(awaddr), .i_axi_awlen(awlen),
    .i_axi_wvalid(wvalid), .o_axi_wready(wready), .i_axi_wdata(wdata),
    .i_axi_wstrb(wstrb), .i_axi_wlast(wlast),
    .o_axi_bvalid(bvalid), .i_axi_bready(bready), .o_axi_bid(bid), .o_axi_bresp(bresp),
    .i_axi_arvalid(arvalid), .o_axi_arready(arready), .i_axi_arid(arid),
    .i_axi_araddr(araddr), .i_axi_arlen(arlen),
    .o_axi_rvalid(rvalid), .i_axi_rready(rready), .o_axi_rid(rid), .o_axi_rdata(rdata),
    .o_axi_rresp(rresp), .o_axi_rlast(rlast)
  );

  always #4 clk = ~clk;

  task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic protocol_error(input string what);
    $display("[ERROR] %0t ns: %s", $time, what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic run_error(input string what);
    $display("At %0t ns: %s", $time, what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  reset_quiet: assert property (@(posedge clk) !rst_n |-> !rvalid && !bvalid)
    else protocol_error("rvalid or bvalid high during reset");
  r_held: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable({rid, rdata, rresp, rlast}))
    else protocol_error("R beat dropped or changed while stalled");
  b_held: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable({bid, bresp}))
    else protocol_error("B response dropped or changed while stalled");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      run_error("timeout, the tests did not finish in the cycle limit.");
    end
  end

  task automatic check_r_beat();
    if (exp_rid.size() == 0) begin
      run_error("an R beat arrived with no read outstanding.");
    end else begin
      assert (rid == exp_rid[0]) else value_error("rid", 32'(rid), 32'(exp_rid[0]));
      assert (rdata == exp_rdata[0]) else value_error("rdata", rdata, exp_rdata[0]);
      assert (rresp == exp_rresp[0]) else value_error("rresp", 32'(rresp), 32'(exp_rresp[0]));
      assert (rlast == exp_rlast[0]) else value_error("rlast", 32'(rlast), 32'(exp_rlast[0]));
      void'(exp_rid.pop_front());
      void'(exp_rdata.pop_front());
      void'(exp_rresp.pop_front());
      void'(exp_rlast.pop_front());
    end
  endtask

  task automatic check_b_beat();
    if (exp_bid.size() == 0) begin
      run_error("a B response arrived with no write outstanding.");
    end else begin
      assert (bid == exp_bid[0]) else value_error("bid", 32'(bid), 32'(exp_bid[0]));
      assert (bresp == OKAY) else value_error("bresp", 32'(bresp), 32'(OKAY));
      void'(exp_bid.pop_front());
    end
  endtask

  // Checks each R and B transfer and drives the ready signals.
  always @(posedge clk) begin
    ready_rand = $random(seed);
    if (rst_n) begin
      if (rvalid && rready) begin
        check_r_beat();
      end
      if (bvalid && bready) begin
        check_b_beat();
      end
    end
    rready <= !random_ready || ready_rand[0];
    bready <= !random_ready || (ready_rand[1] && ready_rand[2]); // Rare, so B backs up.
  end

  function automatic logic [31:0] fill_word(input int word);
    return {16'(word * 4) ^ 16'ha5c3, ~16'(word * 4)};
  endfunction

  task automatic send_aw(input logic [IW-1:0] id, input logic [AW-1:0] addr, input int len);
    @(posedge clk);
    awvalid <= 1'b1;
    awid    <= id;
    awaddr  <= addr;
    awlen   <= 8'(len);
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
  endtask

  task automatic send_w(input int len);
    @(posedge clk);
    for (int k = 0; k <= len; k++) begin
      wvalid <= 1'b1;
      wdata  <= beat_data[4'(k)];
      wstrb  <= beat_strb[4'(k)];
      wlast  <= (k == len);
      do @(posedge clk); while (!wready);
    end
    wvalid <= 1'b0;
  endtask

  task automatic send_ar(input logic [IW-1:0] id, input logic [AW-1:0] addr, input int len);
    @(posedge clk);
    arvalid <= 1'b1;
    arid    <= id;
    araddr  <= addr;
    arlen   <= 8'(len);
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
  endtask

  // Applies the beats in beat_data and beat_strb to the shadow memory, then sends them.
  task automatic write_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr, input int len);
    int          word;
    logic [31:0] mask;
    word = int'(addr >> 2);
    for (int k = 0; k <= len; k++) begin
      mask = {{8{beat_strb[4'(k)][3]}}, {8{beat_strb[4'(k)][2]}},
              {8{beat_strb[4'(k)][1]}}, {8{beat_strb[4'(k)][0]}}};
      if (word + k < WORDS) begin  // Writes beyond the memory are dropped.
        shadow[8'(word + k)] = (shadow[8'(word + k)] & ~mask) | (beat_data[4'(k)] & mask);
      end
    end
    exp_bid.push_back(id);
    fork
      send_aw(id, addr, len);
      send_w(len);
    join
  endtask

  task automatic read_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr, input int len);
    int word;
    word = int'(addr >> 2);
    for (int k = 0; k <= len; k++) begin
      exp_rid.push_back(id);
      if (word + k < WORDS) begin
        exp_rdata.push_back(shadow[8'(word + k)]);
        exp_rresp.push_back(OKAY);
      end else begin
        exp_rdata.push_back('0);
        exp_rresp.push_back(SLVERR);
      end
      exp_rlast.push_back(k == len);
    end
    send_ar(id, addr, len);
  endtask

  task automatic drain();
    while (exp_bid.size() != 0 || exp_rid.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic fill_memory();
    for (int b = 0; b < WORDS / MAX_BURST; b++) begin
      for (int k = 0; k < MAX_BURST; k++) begin
        beat_data[4'(k)] = fill_word(b * MAX_BURST + k);
        beat_strb[4'(k)] = 4'hf;
      end
      write_burst(IW'(b), AW'(b * MAX_BURST * 4), MAX_BURST - 1);
    end
    drain();
  endtask

  // Writes stay in words 128 to 255 while the reads use words 0 to 127 or out of range.
  task automatic write_stream(input int count);
    logic [31:0] r;
    int          len;
    int          word;
    for (int n = 0; n < count; n++) begin
      r    = $random(seed);
      len  = int'(r[3:0]);
      word = 128 + int'(r[15:8]) % (128 - len);
      for (int k = 0; k <= len; k++) begin
        beat_data[4'(k)] = $random(seed);
        beat_strb[4'(k)] = 4'($random(seed));
      end
      write_burst(r[19:16], AW'(word * 4) + AW'(r[21:20]), len);
    end
  endtask

  task automatic read_stream(input int count);
    logic [31:0] r;
    int          len;
    int          word;
    for (int n = 0; n < count; n++) begin
      r   = $random(seed);
      len = int'(r[3:0]);
      if (r[24:22] == 3'd0) begin
        word = WORDS + int'(r[7:0]);
      end else begin
        word = int'(r[15:8]) % (128 - len);
      end
      read_burst(r[19:16], AW'(word * 4), len);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    awvalid      = 1'b0;
    awid         = '0;
    awaddr       = '0;
    awlen        = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wlast        = 1'b0;
    arvalid      = 1'b0;
    arid         = '0;
    araddr       = '0;
    arlen        = '0;
    rready       = 1'b1;
    bready       = 1'b1;
    random_ready = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!rvalid && !bvalid) else protocol_error("rvalid or bvalid high after reset");
    fill_memory();

    beat_data[0] = 32'hdead_beef;
    beat_strb[0] = 4'hf;
    write_burst(4'h3, 16'h0020, 0);
    drain();
    read_burst(4'h5, 16'h0020, 0);
    drain();

    beat_data[0] = 32'h1111_1111;
    beat_data[1] = 32'h2222_2222;
    beat_data[2] = 32'h3333_3333;
    beat_data[3] = 32'h4444_4444;
    beat_strb[0] = 4'b0101;
    beat_strb[1] = 4'b1010;
    beat_strb[2] = 4'b0000;  // The whole word keeps its old value.
    beat_strb[3] = 4'b1001;
    write_burst(4'h7, 16'h0040, 3);
    drain();
    read_burst(4'h2, 16'h0040, 3);
    drain();

    read_burst(4'h9, 16'h0400, 3);  // First word past the end of the memory.
    beat_data[0] = 32'hbad0_0001;
    beat_data[1] = 32'hbad0_0002;
    beat_strb[0] = 4'hf;
    beat_strb[1] = 4'hf;
    write_burst(4'h1, 16'h0404, 1);  // Would alias words 1 and 2 if not dropped.
    drain();
    read_burst(4'h4, 16'h0004, 1);
    drain();

    random_ready <= 1'b1;
    fork
      write_stream(40);
      read_stream(40);
    join
    drain();
    random_ready <= 1'b0;
    for (int n = 0; n < 8; n++) begin
      read_burst(IW'(n), AW'(512 + n * 64), MAX_BURST - 1);
    end
    drain();
    repeat (20) @(posedge clk);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_corebus_top.f ====
design/corebus_pkg.sv
design/corebus_fifo.sv
design/corebus_rr_switch.sv
design/axi2corebus_bridge.sv
design/corebus_sram.sv
design/axi_corebus_top.sv
verif/tb_axi_corebus_top.sv

// ==== Makefile ====
# Verilator build and run of the AXI4 corebus memory testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_axi_corebus_top
FILELIST  ?= axi_corebus_top.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
